//--- flashPkg.sv
`default_nettype none

package flashPkg;

    ////////////////////
    // Widths and command words
    ////////////////////

    // Data bus of the parallel NOR part
    localparam int FLASH_DATA_W = 16;

    // Full address bus of the part, byte-select bit included
    localparam int FLASH_ADDR_DEF_W = 23;

    // Read-array command, written before every read
    localparam logic [FLASH_DATA_W-1:0] FLASH_READ_ARRAY = 16'h00FF;

    ////////////////////
    // Pin bundles
    ////////////////////

    // Control pins, active low apart from vpen
    typedef struct packed {
        logic ce;
        logic oe;
        logic we;
        logic rp;
        logic vpen;
        logic byteMode;
    } flashCtrl_t;

    // Everything the controller drives toward the part
    // The board wrapper builds the tristate pad from dataOut and dataOe
    typedef struct packed {
        flashCtrl_t                  ctrl;
        logic [FLASH_ADDR_DEF_W-1:0] addr;
        logic [FLASH_DATA_W-1:0]     dataOut;
        logic                        dataOe;
    } flashBusOut_t;

endpackage

`default_nettype wire

//--- bootPkg.sv
`default_nettype none

package bootPkg;

    // Word width on the Wishbone side and in the SRAM
    localparam int WORD_W = 16;

    // Full address bus of the SRAM
    localparam int SRAM_ADDR_MAX = 18;

    ////////////////////
    // Bus bundles
    ////////////////////

    // Wishbone classic request, held by the master until ack
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [2:0]        adr;
        logic [WORD_W-1:0] dat;
    } wbReq_t;

    // Wishbone classic response
    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wbRsp_t;

    // Async SRAM pins, en oe we active low
    typedef struct packed {
        logic                     en;
        logic                     oe;
        logic                     we;
        logic [SRAM_ADDR_MAX-1:0] addr;
        logic [WORD_W-1:0]        dataOut;
        logic                     dataOe;
    } sramBusOut_t;

    ////////////////////
    // Copy control
    ////////////////////

    typedef struct packed {
        logic [15:0] startAddr;
        logic [15:0] endAddr;
        logic        go;
    } copyCfg_t;

    typedef struct packed {
        logic              busy;
        logic              done;
        logic [15:0]       count;
        logic [WORD_W-1:0] lastWord;
    } copyStat_t;

    // Register map, word addresses on adr
    localparam logic [2:0] REG_CTRL   = 3'd0;
    localparam logic [2:0] REG_START  = 3'd1;
    localparam logic [2:0] REG_END    = 3'd2;
    localparam logic [2:0] REG_STATUS = 3'd3;
    localparam logic [2:0] REG_COUNT  = 3'd4;
    localparam logic [2:0] REG_LAST   = 3'd5;

endpackage

`default_nettype wire

//--- flashReader.sv
`default_nettype none

module flashReader import flashPkg::*; #(
    parameter int FLASH_ADDR_W = FLASH_ADDR_DEF_W
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdReq,
    input  logic [15:0]             rdAddr,
    output logic [FLASH_DATA_W-1:0] rdData,
    output logic                    rdValid,
    output flashBusOut_t            flashOut,
    input  logic [FLASH_DATA_W-1:0] flashDataIn
);

    // Address bus must fit the pin bundle
    if (FLASH_ADDR_W > FLASH_ADDR_DEF_W) begin : gAddrCheck
        $error("FLASH_ADDR_W wider than the flash address bus");
    end

    typedef enum logic [2:0] {
        stIdle,
        stCmd,
        stRelease,
        stRead,
        stDone
    } readState_t;

    readState_t state;
    logic ceReg;
    logic oeReg;
    logic weReg;
    logic dataOeReg;
    logic [15:0] addrReg;
    logic [FLASH_ADDR_W-1:0] wordAddr;
    logic [FLASH_ADDR_DEF_W-1:0] addrOut;

    // Word address sits above the byte-select bit
    assign wordAddr = FLASH_ADDR_W'({addrReg, 1'b0});

    ////////////////////
    // Read-array sequence
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= stIdle;
            ceReg     <= 1'b1;
            oeReg     <= 1'b1;
            weReg     <= 1'b1;
            dataOeReg <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (rdReq) begin
                        // Select chip and write the command word
                        ceReg     <= 1'b0;
                        weReg     <= 1'b0;
                        dataOeReg <= 1'b1;
                        state     <= stCmd;
                    end
                end
                stCmd: begin
                    // Command latches on the rising we
                    weReg <= 1'b1;
                    state <= stRelease;
                end
                stRelease: begin
                    // Hand the bus back to the part
                    oeReg     <= 1'b0;
                    dataOeReg <= 1'b0;
                    state     <= stRead;
                end
                stRead: begin
                    ceReg <= 1'b1;
                    oeReg <= 1'b1;
                    state <= stDone;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Address and read data, no reset
    always_ff @(posedge clk) begin
        if (state == stIdle && rdReq) begin
            addrReg <= rdAddr;
        end
        if (state == stRelease) begin
            addrOut <= FLASH_ADDR_DEF_W'(wordAddr);
        end
        if (state == stRead) begin
            rdData <= flashDataIn;
        end
    end

    assign rdValid = (state == stDone);

    // Reset pin, program enable and word mode stay inactive
    assign flashOut = '{
        ctrl:    '{ce: ceReg, oe: oeReg, we: weReg, rp: 1'b1, vpen: 1'b1, byteMode: 1'b1},
        addr:    addrOut,
        dataOut: FLASH_READ_ARRAY,
        dataOe:  dataOeReg
    };

    // Command write and array read never overlap
    aWeOe: assert property (@(posedge clk) disable iff (!rst) !(!weReg && !oeReg));
    aChipSel: assert property (@(posedge clk) disable iff (!rst) (!weReg || !oeReg) |-> !ceReg);
    // Fixed latency the copier counts on
    aLatency: assert property (@(posedge clk) disable iff (!rst) rdReq |-> ##4 rdValid);

endmodule

`default_nettype wire

//--- sramWriter.sv
`default_nettype none

module sramWriter import bootPkg::*; #(
    parameter int SRAM_ADDR_W = SRAM_ADDR_MAX
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wrReq,
    input  logic [15:0]       wrAddr,
    input  logic [WORD_W-1:0] wrData,
    output logic              wrDone,
    output sramBusOut_t       sramOut
);

    if (SRAM_ADDR_W > SRAM_ADDR_MAX) begin : gAddrCheck
        $error("SRAM_ADDR_W wider than the SRAM address bus");
    end

    typedef enum logic [1:0] {
        stIdle,
        stWrite,
        stRelease
    } writeState_t;

    writeState_t state;
    logic enReg;
    logic weReg;
    logic dataOeReg;
    logic [SRAM_ADDR_W-1:0] addrExt;
    logic [SRAM_ADDR_MAX-1:0] addrOut;
    logic [WORD_W-1:0] dataReg;

    // Word address zero-extended to the SRAM bus
    assign addrExt = SRAM_ADDR_W'(wrAddr);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= stIdle;
            enReg     <= 1'b1;
            weReg     <= 1'b1;
            dataOeReg <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (wrReq) begin
                        enReg     <= 1'b0;
                        weReg     <= 1'b0;
                        dataOeReg <= 1'b1;
                        state     <= stWrite;
                    end
                end
                stWrite: begin
                    // Data is taken on this rising edge of we
                    weReg <= 1'b1;
                    state <= stRelease;
                end
                default: begin
                    enReg     <= 1'b1;
                    dataOeReg <= 1'b0;
                    state     <= stIdle;
                end
            endcase
        end
    end

    // Captured with the request
    always_ff @(posedge clk) begin
        if (state == stIdle && wrReq) begin
            addrOut <= SRAM_ADDR_MAX'(addrExt);
            dataReg <= wrData;
        end
    end

    assign wrDone = (state == stRelease);

    // Write only, oe held high
    assign sramOut = '{
        en:      enReg,
        oe:      1'b1,
        we:      weReg,
        addr:    addrOut,
        dataOut: dataReg,
        dataOe:  dataOeReg
    };

    aWeInEn: assert property (@(posedge clk) disable iff (!rst) !weReg |-> !enReg);
    aLatency: assert property (@(posedge clk) disable iff (!rst) wrReq |-> ##2 wrDone);

endmodule

`default_nettype wire

//--- bootCopier.sv
`default_nettype none

module bootCopier import bootPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  copyCfg_t          cfg,
    output copyStat_t         stat,
    output logic              rdReq,
    output logic [15:0]       rdAddr,
    input  logic [WORD_W-1:0] rdData,
    input  logic              rdValid,
    output logic              wrReq,
    output logic [15:0]       wrAddr,
    output logic [WORD_W-1:0] wrData,
    input  logic              wrDone
);

    typedef enum logic [1:0] {
        stIdle,
        stRead,
        stWrite
    } copyState_t;

    copyState_t state;
    logic [15:0] curAddr;
    logic [15:0] nextAddr;
    logic [15:0] endReg;
    logic done;
    logic [15:0] count;
    logic [WORD_W-1:0] lastWord;
    logic [WORD_W-1:0] wordBuf;

    assign nextAddr = curAddr + 16'd1;

    ////////////////////
    // Word loop
    ////////////////////

    // Seven cycles per word, four read and two write plus the turn
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= stIdle;
            curAddr  <= '0;
            endReg   <= '0;
            rdReq    <= 1'b0;
            done     <= 1'b0;
            count    <= '0;
            lastWord <= '0;
        end else begin
            rdReq <= 1'b0;
            case (state)
                stIdle: begin
                    if (cfg.go) begin
                        curAddr <= cfg.startAddr;
                        endReg  <= cfg.endAddr;
                        count   <= '0;
                        if (cfg.startAddr < cfg.endAddr) begin
                            rdReq <= 1'b1;
                            done  <= 1'b0;
                            state <= stRead;
                        end else begin
                            // Empty range finishes at once
                            done <= 1'b1;
                        end
                    end
                end
                stRead: begin
                    if (rdValid) begin
                        state <= stWrite;
                    end
                end
                default: begin
                    if (wrDone) begin
                        count    <= count + 16'd1;
                        lastWord <= wordBuf;
                        if (nextAddr < endReg) begin
                            curAddr <= nextAddr;
                            rdReq   <= 1'b1;
                            state   <= stRead;
                        end else begin
                            done  <= 1'b1;
                            state <= stIdle;
                        end
                    end
                end
            endcase
        end
    end

    // Keep the word for the status register
    always_ff @(posedge clk) begin
        if (rdValid) begin
            wordBuf <= rdData;
        end
    end

    assign rdAddr = curAddr;
    // Write starts in the same cycle the word arrives
    assign wrReq  = (state == stRead) && rdValid;
    assign wrAddr = curAddr;
    assign wrData = rdData;

    assign stat = '{
        busy:     (state != stIdle),
        done:     done,
        count:    count,
        lastWord: lastWord
    };

    // Register block gates start with busy
    aGoIdle: assert property (@(posedge clk) disable iff (!rst) cfg.go |-> !stat.busy);
    aDoneInWrite: assert property (@(posedge clk) disable iff (!rst)
        wrDone |-> state == stWrite);

endmodule

`default_nettype wire

//--- bootRegs.sv
`default_nettype none

module bootRegs import bootPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  wbReq_t    wbIn,
    output wbRsp_t    wbOut,
    output copyCfg_t  cfg,
    input  copyStat_t stat
);

    logic ackReg;
    logic goReg;
    logic access;
    logic wrAccess;
    logic [15:0] startReg;
    logic [15:0] endReg;
    logic [WORD_W-1:0] rdMux;
    logic [WORD_W-1:0] rdDat;

    // New access only when no ack is out so ack never repeats
    assign access   = wbIn.cyc && wbIn.stb && !ackReg;
    assign wrAccess = access && wbIn.we;

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            ackReg   <= 1'b0;
            goReg    <= 1'b0;
            startReg <= '0;
            endReg   <= '0;
        end else begin
            ackReg <= access;
            // Start ignored while a copy runs
            goReg  <= wrAccess && (wbIn.adr == REG_CTRL) && wbIn.dat[0] && !stat.busy;
            if (wrAccess) begin
                case (wbIn.adr)
                    REG_START: startReg <= wbIn.dat;
                    REG_END:   endReg   <= wbIn.dat;
                    default:   ;
                endcase
            end
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    always_comb begin
        rdMux = '0;
        case (wbIn.adr)
            REG_START:  rdMux = startReg;
            REG_END:    rdMux = endReg;
            REG_STATUS: begin
                rdMux[0] = stat.busy;
                rdMux[1] = stat.done;
            end
            REG_COUNT:  rdMux = stat.count;
            REG_LAST:   rdMux = stat.lastWord;
            // Control and unmapped addresses read zero
            default:    rdMux = '0;
        endcase
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            rdDat <= rdMux;
        end
    end

    assign wbOut = '{ack: ackReg, dat: rdDat};
    assign cfg   = '{startAddr: startReg, endAddr: endReg, go: goReg};

endmodule

`default_nettype wire

//--- bootLoader.sv
`default_nettype none

module bootLoader import flashPkg::*, bootPkg::*; #(
    parameter int FLASH_ADDR_W = FLASH_ADDR_DEF_W,
    parameter int SRAM_ADDR_W  = SRAM_ADDR_MAX
) (
    input  logic                    clk,
    input  logic                    rst,
    input  wbReq_t                  wbIn,
    output wbRsp_t                  wbOut,
    output flashBusOut_t            flashOut,
    input  logic [FLASH_DATA_W-1:0] flashDataIn,
    output sramBusOut_t             sramOut
);

    copyCfg_t cfg;
    copyStat_t stat;

    // Copier to flash side
    logic rdReq;
    logic [15:0] rdAddr;
    logic [FLASH_DATA_W-1:0] rdData;
    logic rdValid;

    // Copier to SRAM side
    logic wrReq;
    logic [15:0] wrAddr;
    logic [WORD_W-1:0] wrData;
    logic wrDone;

    bootRegs regs (
        .clk (clk),
        .rst (rst),
        .wbIn (wbIn),
        .wbOut (wbOut),
        .cfg (cfg),
        .stat (stat)
    );

    bootCopier copier (
        .clk (clk),
        .rst (rst),
        .cfg (cfg),
        .stat (stat),
        .rdReq (rdReq),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .rdValid (rdValid),
        .wrReq (wrReq),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wrDone (wrDone)
    );

    flashReader #(.FLASH_ADDR_W(FLASH_ADDR_W)) reader (
        .clk (clk),
        .rst (rst),
        .rdReq (rdReq),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .rdValid (rdValid),
        .flashOut (flashOut),
        .flashDataIn (flashDataIn)
    );

    sramWriter #(.SRAM_ADDR_W(SRAM_ADDR_W)) writer (
        .clk (clk),
        .rst (rst),
        .wrReq (wrReq),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wrDone (wrDone),
        .sramOut (sramOut)
    );

endmodule

`default_nettype wire

//--- tbMemModels.sv
`default_nettype none

////////////////////
// Parallel NOR flash
////////////////////

module flashModel import flashPkg::*; (
    input  flashBusOut_t            flashIn,
    output logic [FLASH_DATA_W-1:0] dataIn,
    output logic                    cmdError
);

    timeunit 1ns;
    timeprecision 1ps;

    // One word per word address, random contents
    logic [FLASH_DATA_W-1:0] mem [0:65535];
    logic [15:0] wordAddr;
    logic errFlag = 1'b0;

    // Byte-select bit sits below the word address
    assign wordAddr = flashIn.addr[16:1];

    initial begin
        logic [16:0] i;
        int unsigned seedDiscard;
        // Single seeding for the whole run
        seedDiscard = $urandom(32'h7ee0);
        for (i = 0; i < 17'h10000; i++) begin
            mem[i[15:0]] = 16'($urandom);
        end
    end

    // Array read while chip and output are selected
    assign dataIn = (!flashIn.ctrl.ce && !flashIn.ctrl.oe) ? mem[wordAddr] : 16'h0000;

    // Command latches on rising we, only read-array is legal here
    always @(posedge flashIn.ctrl.we) begin
        if (!flashIn.ctrl.ce && flashIn.dataOe) begin
            if (flashIn.dataOut != FLASH_READ_ARRAY) begin
                $display("Flash model received a command other than read-array: %h",
                    flashIn.dataOut);
                errFlag <= 1'b1;
            end
        end
    end

    assign cmdError = errFlag;

endmodule

////////////////////
// Async SRAM
////////////////////

module sramModel import bootPkg::*; #(
    parameter logic [15:0] FILL_KEY = 16'h0000
) (
    input  sramBusOut_t sramIn,
    output int          writeCount
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [WORD_W-1:0] mem [0:65535];
    int writes = 0;

    // Known contents, every word tied to its own address
    initial begin
        logic [16:0] i;
        for (i = 0; i < 17'h10000; i++) begin
            mem[i[15:0]] = i[15:0] ^ FILL_KEY;
        end
    end

    // Data taken on rising we while enabled and driven
    always @(posedge sramIn.we) begin
        if (!sramIn.en && sramIn.dataOe) begin
            mem[sramIn.addr[15:0]] <= sramIn.dataOut;
            writes <= writes + 1;
        end
    end

    assign writeCount = writes;

endmodule

`default_nettype wire

//--- bootLoaderTb.sv
`default_nettype none

module bootLoaderTb import flashPkg::*, bootPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES = 6;
    localparam logic [15:0] FILL_KEY = 16'hA55A;

    // One row per copy case
    typedef struct packed {
        logic [15:0] startAddr;
        logic [15:0] endAddr;
        logic        restart;
        logic [15:0] expCount;
    } caseRow_t;

    // Disjoint ranges so neighbours stay at the fill value
    localparam caseRow_t CASES [NUM_CASES] = '{
        '{16'h0010, 16'h0011, 1'b0, 16'd1},
        '{16'h0100, 16'h0108, 1'b0, 16'd8},
        '{16'h0400, 16'h0440, 1'b0, 16'd64},
        '{16'h0900, 16'h0880, 1'b0, 16'd0},
        '{16'hFFC0, 16'hFFFF, 1'b0, 16'd63},
        '{16'h2000, 16'h2010, 1'b1, 16'd16}
    };
    string caseNames [NUM_CASES] = '{
        "single word", "short range", "range of 64", "empty range",
        "near top", "restart while busy"
    };

    logic clk;
    logic rst;
    wbReq_t wbIn;
    wbRsp_t wbOut;
    flashBusOut_t flashOut;
    logic [FLASH_DATA_W-1:0] flashDataIn;
    sramBusOut_t sramOut;
    logic cmdError;
    int writeCount;

    logic [15:0] flashCopy [0:65535];
    int cycles = 0;
    int cycleLimit;
    int failCount;
    int passCases;
    int failCases;
    logic caseBad;
    string curName;
    logic started;
    logic earlyLow = 1'b0;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    bootLoader #(.FLASH_ADDR_W(23), .SRAM_ADDR_W(18)) uut (
        .clk (clk),
        .rst (rst),
        .wbIn (wbIn),
        .wbOut (wbOut),
        .flashOut (flashOut),
        .flashDataIn (flashDataIn),
        .sramOut (sramOut)
    );

    flashModel flash (
        .flashIn (flashOut),
        .dataIn (flashDataIn),
        .cmdError (cmdError)
    );

    sramModel #(.FILL_KEY(FILL_KEY)) sram (
        .sramIn (sramOut),
        .writeCount (writeCount)
    );

    ////////////////////
    // Watchdogs
    ////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run went past its limit of %0d cycles", cycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    // Any memory strobe before the first start
    always @(posedge clk) begin
        if (rst && !started) begin
            if (!flashOut.ctrl.ce || !flashOut.ctrl.oe || !flashOut.ctrl.we ||
                    !flashOut.ctrl.rp || !flashOut.ctrl.vpen || !flashOut.ctrl.byteMode ||
                    !sramOut.en || !sramOut.oe || !sramOut.we) begin
                earlyLow <= 1'b1;
            end
        end
    end

    ////////////////////
    // Bus tasks
    ////////////////////

    // Request held until ack and then released
    task automatic wbWrite(input logic [2:0] addr, input logic [15:0] data);
        @(posedge clk);
        wbIn <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
        do begin
            @(posedge clk);
        end while (!wbOut.ack);
        wbIn <= '0;
    endtask

    task automatic wbRead(input logic [2:0] addr, output logic [15:0] data);
        @(posedge clk);
        wbIn <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 16'h0000};
        do begin
            @(posedge clk);
        end while (!wbOut.ack);
        data = wbOut.dat;
        wbIn <= '0;
    endtask

    task automatic reportMismatch(input string what, input logic [15:0] exp,
            input logic [15:0] act);
        $display("ERROR %s, %s: expected %h, actual %h", curName, what, exp, act);
        failCount++;
        caseBad = 1'b1;
    endtask

    task automatic finishCase();
        if (caseBad) begin
            failCases++;
            $display("FAIL  %s", curName);
        end else begin
            passCases++;
            $display("PASS  %s", curName);
        end
    endtask

    ////////////////////
    // One table row
    ////////////////////

    task automatic runCase(input int idx);
        caseRow_t row;
        logic [15:0] rd;
        logic [15:0] lowOut;
        logic [15:0] highOut;
        int writesBefore;
        int bad;
        int a;
        row = CASES[idx];
        curName = caseNames[idx];
        caseBad = 1'b0;
        writesBefore = writeCount;

        // Range registers and unmapped reads
        wbWrite(REG_START, row.startAddr);
        wbWrite(REG_END, row.endAddr);
        wbRead(REG_START, rd);
        if (rd !== row.startAddr) reportMismatch("start readback", row.startAddr, rd);
        wbRead(REG_END, rd);
        if (rd !== row.endAddr) reportMismatch("end readback", row.endAddr, rd);
        wbRead(3'd6, rd);
        if (rd !== 16'h0000) reportMismatch("unmapped address 6", 16'h0000, rd);
        wbRead(3'd7, rd);
        if (rd !== 16'h0000) reportMismatch("unmapped address 7", 16'h0000, rd);

        // Strobes seen during the register setup of the first case
        if (!started && earlyLow) begin
            $display("%s: a memory control went low before the first start", curName);
            failCount++;
            caseBad = 1'b1;
        end

        started = 1'b1;
        wbWrite(REG_CTRL, 16'h0001);
        if (row.restart) begin
            // Busy with done cleared before a second start that is ignored
            wbRead(REG_STATUS, rd);
            if (rd !== 16'h0001) reportMismatch("status mid-copy", 16'h0001, rd);
            wbWrite(REG_CTRL, 16'h0001);
        end
        do begin
            wbRead(REG_STATUS, rd);
        end while (rd[1] !== 1'b1);
        if (rd !== 16'h0002) reportMismatch("status at done", 16'h0002, rd);

        wbRead(REG_COUNT, rd);
        if (rd !== row.expCount) reportMismatch("word count", row.expCount, rd);
        if (writeCount - writesBefore != int'(row.expCount)) begin
            reportMismatch("SRAM writes", row.expCount, 16'(writeCount - writesBefore));
        end

        if (row.expCount != 16'd0) begin
            wbRead(REG_LAST, rd);
            if (rd !== flashCopy[row.endAddr - 16'd1]) begin
                reportMismatch("last word", flashCopy[row.endAddr - 16'd1], rd);
            end
            // Whole range against the flash copy with only the first miss reported
            bad = 0;
            for (a = int'(row.startAddr); a < int'(row.endAddr); a++) begin
                if (sram.mem[a[15:0]] !== flashCopy[a[15:0]]) begin
                    if (bad == 0) begin
                        reportMismatch($sformatf("SRAM word %h", a[15:0]),
                            flashCopy[a[15:0]], sram.mem[a[15:0]]);
                    end
                    bad++;
                end
            end
            if (bad > 1) $display("%s: %0d SRAM words differ from flash in total", curName, bad);
        end

        // Neighbours outside the range keep the fill value
        lowOut = row.startAddr - 16'd1;
        highOut = (row.expCount != 16'd0) ? row.endAddr : row.startAddr;
        if (sram.mem[lowOut] !== (lowOut ^ FILL_KEY)) begin
            reportMismatch("word below range", lowOut ^ FILL_KEY, sram.mem[lowOut]);
        end
        if (sram.mem[highOut] !== (highOut ^ FILL_KEY)) begin
            reportMismatch("word above range", highOut ^ FILL_KEY, sram.mem[highOut]);
        end

        if (cmdError) begin
            $display("%s: flash model saw an illegal command", curName);
            failCount++;
            caseBad = 1'b1;
        end
        finishCase();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [15:0] rd;
        logic [16:0] i;
        int k;
        rst = 1'b0;
        wbIn = '0;
        started = 1'b0;
        failCount = 0;
        passCases = 0;
        failCases = 0;

        // 8 cycles per word plus 50 per case
        cycleLimit = 0;
        for (k = 0; k < NUM_CASES; k++) begin
            if (CASES[k].endAddr > CASES[k].startAddr) begin
                cycleLimit += 8 * int'(CASES[k].endAddr - CASES[k].startAddr);
            end
            cycleLimit += 50;
        end

        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        for (i = 0; i < 17'h10000; i++) begin
            flashCopy[i[15:0]] = flash.mem[i[15:0]];
        end

        // Idle state straight after reset
        curName = "reset";
        caseBad = 1'b0;
        wbRead(REG_STATUS, rd);
        if (rd !== 16'h0000) reportMismatch("status after reset", 16'h0000, rd);
        if (earlyLow) begin
            $display("reset: a flash or SRAM control went low before any start");
            failCount++;
            caseBad = 1'b1;
        end
        finishCase();

        for (k = 0; k < NUM_CASES; k++) begin
            runCase(k);
        end

        $display("Tests: %0d passed, %0d failed, %0d checks failed",
            passCases, failCases, failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
flashPkg.sv
bootPkg.sv
flashReader.sv
sramWriter.sv
bootCopier.sv
bootRegs.sv
bootLoader.sv
tbMemModels.sv
bootLoaderTb.sv

//--- run.sh
#!/bin/sh

verilator --binary --timing --assert -f list.f --top-module bootLoaderTb -o simBoot
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simBoot)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx 'All tests passed!'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
